/* include/vic_params.svh */
`ifndef VIC_PARAMS_SVH
`define VIC_PARAMS_SVH

// pal raster limits, 504 dots by 312 lines
`define RASTER_X_MAX     10'd503
`define RASTER_Y_MAX     9'd311

// xpos restart points and the cycle where it wraps to zero
`define XPOS_LINE_START  10'h194
`define XPOS_CYCLE0      10'h195
`define XPOS_WRAP_CYCLE  7'd12

// display enable window
`define DEN_LINE_ON      9'd48
`define DEN_LINE_OFF     9'd248

// top and bottom border lines for rsel 1 and 0
`define TB_OPEN_RSEL1    9'd51
`define TB_OPEN_RSEL0    9'd55
`define TB_CLOSE_RSEL0   9'd247
`define TB_CLOSE_RSEL1   9'd251

// left and right border xpos for csel 1 and 0
`define LR_OPEN_CSEL1    10'd25
`define LR_OPEN_CSEL0    10'd32
`define LR_CLOSE_CSEL0   10'd336
`define LR_CLOSE_CSEL1   10'd345

// clocks per phi phase, and tick where write data is taken
`define PHASE_TICKS      16
`define REG_DAV          7

`endif

/* hw/vicPkg.sv */
package vicPkg;

  // --------------------------------------------------
  // palette, 16 entries in hardware order
  // --------------------------------------------------
  typedef enum logic [3:0] {
    BLACK, WHITE, RED, CYAN, PURPLE, GREEN, BLUE, YELLOW,
    ORANGE, BROWN, PINK, DARK_GREY, GREY, LIGHT_GREEN, LIGHT_BLUE, LIGHT_GREY
  } vicColor;

  // --------------------------------------------------
  // cpu visible register offsets
  // --------------------------------------------------
  typedef enum logic [5:0] {
    REG_SCREEN_CONTROL_1   = 6'h11,
    REG_RASTER_LINE        = 6'h12,
    REG_SCREEN_CONTROL_2   = 6'h16,
    REG_MEMORY_SETUP       = 6'h18,
    REG_INTERRUPT_STATUS   = 6'h19,
    REG_INTERRUPT_CONTROL  = 6'h1A,
    REG_BORDER_COLOR       = 6'h20,
    REG_BACKGROUND_COLOR_0 = 6'h21,
    REG_BACKGROUND_COLOR_1 = 6'h22,
    REG_BACKGROUND_COLOR_2 = 6'h23,
    REG_BACKGROUND_COLOR_3 = 6'h24
  } vicRegAddr;

  // low phase belongs to the video side, high phase to the cpu
  typedef enum logic {PHI_LOW = 1'b0, PHI_HIGH = 1'b1} vicPhiPhase;

endpackage

/* hw/vicIf.sv */
`timescale 1ns/10ps
`include "vic_params.svh"

// --------------------------------------------------
// phase and dot timing from the clock generator
// --------------------------------------------------
interface vicTimingIf import vicPkg::*; ();
  vicPhiPhase phi;
  // one hot, bit n high on clock n of the current phase
  logic [`PHASE_TICKS-1:0] phaseTick;
  logic dotRise;
  logic phaseEnd;

  modport gen (output phi, phaseTick, dotRise, phaseEnd);
  modport user (input phi, phaseTick, dotRise, phaseEnd);
endinterface

// --------------------------------------------------
// register fields and beam state between units
// --------------------------------------------------
interface vicCtrlIf import vicPkg::*; ();
  // from the register file
  logic den;
  logic rsel;
  logic csel;
  logic [8:0] rasterCmp;
  logic irqClear;
  vicColor borderColor;
  vicColor bgColor0;
  // from the raster counters
  logic [8:0] rasterLine;
  logic [9:0] xpos;
  logic [6:0] cycleNum;
  logic rasterEnable;
  logic rasterHit;

  modport regs (output den, rsel, csel, rasterCmp, irqClear, borderColor, bgColor0,
                input rasterLine, rasterHit);
  modport raster (input den, rasterCmp,
                  output rasterLine, xpos, cycleNum, rasterEnable, rasterHit);
  modport border (input rsel, csel, borderColor, bgColor0, rasterLine, xpos, rasterEnable);
endinterface

/* hw/vicClockGen.sv */
`timescale 1ns/10ps
`include "vic_params.svh"

module vicClockGen import vicPkg::*; (
  input  logic clk_dot4x,
  input  logic rst,
  vicTimingIf.gen timing,
  output logic clkPhi
);

  // phiRing[31] is phi, 16 clocks low then 16 high
  logic [31:0] phiRing;
  // dotRing[0] marks a dot clock rising edge
  logic [15:0] dotRing;
  // phaseRing bit n set on clock n of a phase
  logic [`PHASE_TICKS-1:0] phaseRing;

  // --------------------------------------------------
  // rotating rings, all advance every clk_dot4x
  // --------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      // start at tick 0 of a phi low phase
      phiRing   <= 32'h0000_FFFF;
      dotRing   <= 16'h1111;
      phaseRing <= {{(`PHASE_TICKS-1){1'b0}}, 1'b1};
    end else begin
      phiRing   <= {phiRing[30:0], phiRing[31]};
      dotRing   <= {dotRing[14:0], dotRing[15]};
      phaseRing <= {phaseRing[`PHASE_TICKS-2:0], phaseRing[`PHASE_TICKS-1]};
    end
  end

  assign clkPhi = phiRing[31];

  // phase state for the other units
  assign timing.phi       = vicPhiPhase'(phiRing[31]);
  assign timing.phaseTick = phaseRing;
  assign timing.dotRise   = dotRing[0];
  // last tick, phi toggles on the following edge
  assign timing.phaseEnd  = phaseRing[`PHASE_TICKS-1];

endmodule

/* hw/vicRegDecode.sv */
`timescale 1ns/10ps
`include "vic_params.svh"

module vicRegDecode import vicPkg::*; (
  input  logic clk_dot4x,
  input  logic rst,
  vicTimingIf.user timing,
  vicCtrlIf.regs ctrl,
  input  logic ce,
  input  logic rw,
  input  logic [5:0] adi,
  input  logic [7:0] dbi,
  output logic [7:0] dbo,
  output logic irq
);

  vicRegAddr regAddr;
  logic cpuAccess;
  logic writeStrobe;
  // fields kept only for read back
  logic [2:0] yscroll;
  logic [2:0] xscroll;
  logic bmm;
  logic ecm;
  logic mcm;
  logic res;
  logic [2:0] cb;
  logic [3:0] vm;
  logic [3:0] irqEnable;
  vicColor bgColor1;
  vicColor bgColor2;
  vicColor bgColor3;
  // raster interrupt status
  logic rasterIrq;

  assign regAddr = vicRegAddr'(adi);
  // chip selected during the cpu half of phi
  assign cpuAccess = (timing.phi == PHI_HIGH) && !ce;
  assign writeStrobe = cpuAccess && !rw && timing.phaseTick[`REG_DAV];

  // --------------------------------------------------
  // register writes, data taken on tick REG_DAV
  // --------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      yscroll          <= 3'd3;
      ctrl.rsel        <= 1'b1;
      ctrl.den         <= 1'b1;
      bmm              <= 1'b0;
      ecm              <= 1'b0;
      ctrl.rasterCmp   <= 9'd0;
      xscroll          <= 3'd0;
      ctrl.csel        <= 1'b0;
      mcm              <= 1'b0;
      res              <= 1'b0;
      cb               <= 3'd0;
      vm               <= 4'd0;
      irqEnable        <= 4'd0;
      ctrl.irqClear    <= 1'b0;
      ctrl.borderColor <= BLACK;
      ctrl.bgColor0    <= BLACK;
      bgColor1         <= BLACK;
      bgColor2         <= BLACK;
      bgColor3         <= BLACK;
    end else begin
      // clear request is a single clock pulse
      ctrl.irqClear <= 1'b0;
      if (writeStrobe) begin
        case (regAddr)
          REG_SCREEN_CONTROL_1: begin
            yscroll           <= dbi[2:0];
            ctrl.rsel         <= dbi[3];
            ctrl.den          <= dbi[4];
            bmm               <= dbi[5];
            ecm               <= dbi[6];
            ctrl.rasterCmp[8] <= dbi[7];
          end
          REG_RASTER_LINE: ctrl.rasterCmp[7:0] <= dbi;
          REG_SCREEN_CONTROL_2: begin
            xscroll   <= dbi[2:0];
            ctrl.csel <= dbi[3];
            mcm       <= dbi[4];
            res       <= dbi[5];
          end
          REG_MEMORY_SETUP: begin
            cb <= dbi[3:1];
            vm <= dbi[7:4];
          end
          // write 1 to acknowledge
          REG_INTERRUPT_STATUS:   ctrl.irqClear    <= dbi[0];
          REG_INTERRUPT_CONTROL:  irqEnable        <= dbi[3:0];
          REG_BORDER_COLOR:       ctrl.borderColor <= vicColor'(dbi[3:0]);
          REG_BACKGROUND_COLOR_0: ctrl.bgColor0    <= vicColor'(dbi[3:0]);
          REG_BACKGROUND_COLOR_1: bgColor1         <= vicColor'(dbi[3:0]);
          REG_BACKGROUND_COLOR_2: bgColor2         <= vicColor'(dbi[3:0]);
          REG_BACKGROUND_COLOR_3: bgColor3         <= vicColor'(dbi[3:0]);
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------
  // raster interrupt, a new hit wins over a clear
  // --------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterIrq <= 1'b0;
    end else if (ctrl.rasterHit) begin
      rasterIrq <= 1'b1;
    end else if (ctrl.irqClear) begin
      rasterIrq <= 1'b0;
    end
  end

  assign irq = rasterIrq & irqEnable[0];

  // --------------------------------------------------
  // read mux, refreshed each clock of a read access
  // --------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dbo <= 8'hFF;
    end else if (cpuAccess && rw) begin
      case (regAddr)
        REG_SCREEN_CONTROL_1:
          dbo <= {ctrl.rasterLine[8], ecm, bmm, ctrl.den, ctrl.rsel, yscroll};
        REG_RASTER_LINE:        dbo <= ctrl.rasterLine[7:0];
        REG_SCREEN_CONTROL_2:   dbo <= {2'b11, res, mcm, ctrl.csel, xscroll};
        REG_MEMORY_SETUP:       dbo <= {vm, cb, 1'b1};
        // bit 7 mirrors the irq line
        REG_INTERRUPT_STATUS:   dbo <= {irq, 6'h3F, rasterIrq};
        REG_INTERRUPT_CONTROL:  dbo <= {4'hF, irqEnable};
        REG_BORDER_COLOR:       dbo <= {4'hF, ctrl.borderColor};
        REG_BACKGROUND_COLOR_0: dbo <= {4'hF, ctrl.bgColor0};
        REG_BACKGROUND_COLOR_1: dbo <= {4'hF, bgColor1};
        REG_BACKGROUND_COLOR_2: dbo <= {4'hF, bgColor2};
        REG_BACKGROUND_COLOR_3: dbo <= {4'hF, bgColor3};
        default:                dbo <= 8'hFF;
      endcase
    end
  end

endmodule

/* hw/vicRasterTiming.sv */
`timescale 1ns/10ps
`include "vic_params.svh"

module vicRasterTiming import vicPkg::*; (
  input  logic clk_dot4x,
  input  logic rst,
  vicTimingIf.user timing,
  vicCtrlIf.raster ctrl,
  output logic [9:0] rasterX,
  output logic [8:0] rasterLine
);

  logic [9:0] xpos;
  // high on tick 0 of a phi high phase
  logic highStart;
  // line advance held until cycle 0, frame restart until cycle 1
  logic startOfLine;
  logic startOfFrame;
  logic lineEnd;
  logic lineAdvance;
  logic frameRestart;
  logic hitCycle;
  logic hitDone;

  assign ctrl.cycleNum   = rasterX[9:3];
  assign ctrl.rasterLine = rasterLine;
  assign ctrl.xpos       = xpos;

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      highStart <= 1'b0;
    end else begin
      highStart <= timing.phaseEnd && (timing.phi == PHI_LOW);
    end
  end

  assign lineEnd = (rasterX == `RASTER_X_MAX);
  assign frameRestart = timing.dotRise && highStart && !lineEnd &&
                        startOfFrame && (ctrl.cycleNum == 7'd1);
  assign lineAdvance = timing.dotRise && highStart && !lineEnd &&
                       startOfLine && (ctrl.cycleNum == 7'd0);

  // --------------------------------------------------
  // beam counters, step once per dot
  // --------------------------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterX      <= 10'd0;
      rasterLine   <= 9'd0;
      xpos         <= `XPOS_LINE_START;
      startOfLine  <= 1'b0;
      startOfFrame <= 1'b0;
    end else if (timing.dotRise) begin
      if (!lineEnd) begin
        rasterX <= rasterX + 10'd1;
        if (frameRestart) begin
          rasterLine   <= 9'd0;
          startOfFrame <= 1'b0;
        end else if (lineAdvance) begin
          rasterLine  <= rasterLine + 9'd1;
          startOfLine <= 1'b0;
        end
        // pal xpos skips ahead in cycle 0 and wraps in cycle 12
        if (ctrl.cycleNum == 7'd0 && rasterX[2:0] == 3'd0) begin
          xpos <= `XPOS_CYCLE0;
        end else if (ctrl.cycleNum == `XPOS_WRAP_CYCLE && rasterX[2:0] == 3'd3) begin
          xpos <= 10'd0;
        end else begin
          xpos <= xpos + 10'd1;
        end
      end else begin
        rasterX <= 10'd0;
        xpos    <= `XPOS_LINE_START;
        if (rasterLine == `RASTER_Y_MAX) begin
          startOfFrame <= 1'b1;
        end else begin
          startOfLine <= 1'b1;
        end
      end
    end
  end

  // den only counts while the beam is on line 48
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      ctrl.rasterEnable <= 1'b0;
    end else if (timing.dotRise) begin
      if (rasterLine == `DEN_LINE_ON && ctrl.den) begin
        ctrl.rasterEnable <= 1'b1;
      end
      if (rasterLine == `DEN_LINE_OFF) begin
        ctrl.rasterEnable <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // raster compare, line 0 matches in cycle 1
  // --------------------------------------------------
  assign hitCycle = (rasterLine == 9'd0) ? (ctrl.cycleNum == 7'd1) : (ctrl.cycleNum == 7'd0);

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      ctrl.rasterHit <= 1'b0;
      hitDone        <= 1'b0;
    end else begin
      ctrl.rasterHit <= 1'b0;
      if (!hitDone && hitCycle && rasterLine == ctrl.rasterCmp) begin
        ctrl.rasterHit <= 1'b1;
        hitDone        <= 1'b1;
      end
      // rearm as the new line is entered
      if (lineAdvance || frameRestart) begin
        hitDone <= 1'b0;
      end
    end
  end

endmodule

/* hw/vicBorderColor.sv */
`timescale 1ns/10ps
`include "vic_params.svh"

module vicBorderColor import vicPkg::*; (
  input  logic clk_dot4x,
  input  logic rst,
  vicTimingIf.user timing,
  vicCtrlIf.border ctrl,
  output vicColor colorIndex
);

  logic tbBorder;
  logic lrBorder;
  logic nextTbBorder;
  // dotRise delayed by one and two clocks
  logic [1:0] dotPipe;

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dotPipe <= 2'b00;
    end else begin
      dotPipe <= {dotPipe[0], timing.dotRise};
    end
  end

  // --------------------------------------------------
  // vertical border, later rules take priority
  // --------------------------------------------------
  always_comb begin
    nextTbBorder = tbBorder;
    if (ctrl.rasterLine == `TB_OPEN_RSEL0 && ctrl.rasterEnable) begin
      nextTbBorder = 1'b0;
    end
    if (ctrl.rasterLine == `TB_OPEN_RSEL1 && ctrl.rsel && ctrl.rasterEnable) begin
      nextTbBorder = 1'b0;
    end
    if (ctrl.rasterLine == `TB_CLOSE_RSEL0 && !ctrl.rsel) begin
      nextTbBorder = 1'b1;
    end
    if (ctrl.rasterLine == `TB_CLOSE_RSEL1 && ctrl.rsel) begin
      nextTbBorder = 1'b1;
    end
  end

  // the vertical flag is only sampled at the left edge
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      tbBorder <= 1'b1;
      lrBorder <= 1'b1;
    end else if (dotPipe[0]) begin
      if ((ctrl.xpos == `LR_OPEN_CSEL0 && !ctrl.csel) ||
          (ctrl.xpos == `LR_OPEN_CSEL1 && ctrl.csel)) begin
        lrBorder <= nextTbBorder;
        tbBorder <= nextTbBorder;
      end
      if ((ctrl.xpos == `LR_CLOSE_CSEL0 && !ctrl.csel) ||
          (ctrl.xpos == `LR_CLOSE_CSEL1 && ctrl.csel)) begin
        lrBorder <= 1'b1;
      end
    end
  end

  // border colour wins over the window
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      colorIndex <= BLACK;
    end else if (dotPipe[1]) begin
      colorIndex <= (lrBorder || tbBorder) ? ctrl.borderColor : ctrl.bgColor0;
    end
  end

endmodule

/* hw/vicCore.sv */
`timescale 1ns/10ps

module vicCore import vicPkg::*; (
  input  logic clk_dot4x,
  input  logic rst,
  input  logic ce,
  input  logic rw,
  input  logic [5:0] adi,
  input  logic [7:0] dbi,
  output logic clkPhi,
  output logic [7:0] dbo,
  output logic irq,
  output logic [9:0] rasterX,
  output logic [8:0] rasterLine,
  output vicColor colorIndex
);

  // --------------------------------------------------
  // internal buses
  // --------------------------------------------------
  vicTimingIf timingBus ();
  vicCtrlIf ctrlBus ();

  // phi, dot strobe and phase ticks
  vicClockGen clockGen_i (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .timing    (timingBus),
    .clkPhi    (clkPhi)
  );

  // cpu side register file
  vicRegDecode regDecode_i (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .timing    (timingBus),
    .ctrl      (ctrlBus),
    .ce        (ce),
    .rw        (rw),
    .adi       (adi),
    .dbi       (dbi),
    .dbo       (dbo),
    .irq       (irq)
  );

  // beam position and raster compare
  vicRasterTiming rasterTiming_i (
    .clk_dot4x  (clk_dot4x),
    .rst        (rst),
    .timing     (timingBus),
    .ctrl       (ctrlBus),
    .rasterX    (rasterX),
    .rasterLine (rasterLine)
  );

  // border versus window colour
  vicBorderColor borderColor_i (
    .clk_dot4x  (clk_dot4x),
    .rst        (rst),
    .timing     (timingBus),
    .ctrl       (ctrlBus),
    .colorIndex (colorIndex)
  );

endmodule

/* verification/vicCoreTb.sv */
`timescale 1ns/10ps
`include "vic_params.svh"

module vicCoreTb import vicPkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int MAX_VECTORS = 256;
  // clock budget per vector, two phi cycles
  localparam int VECTOR_CLOCKS = 64;

  logic clk_dot4x;
  logic rst;
  logic ce;
  logic rw;
  logic [5:0] adi;
  logic [7:0] dbi;
  logic clkPhi;
  logic [7:0] dbo;
  logic irq;
  logic [9:0] rasterX;
  logic [8:0] rasterLine;
  vicColor colorIndex;

  // vector table, one entry per file line
  logic [7:0] vecCmd [MAX_VECTORS];
  logic [11:0] vecAddr [MAX_VECTORS];
  logic [7:0] vecData [MAX_VECTORS];
  logic [7:0] vecExpect [MAX_VECTORS];
  int vecCount;
  logic vectorsLoaded;
  int checkCount;
  int errorCount;
  int lineErrors;
  int wrapCount;
  logic [8:0] prevLine;
  logic [8:0] nextLine;
  // phi and dot stepping
  int timingErrors;
  logic prevPhi;
  int phiClocks;
  logic [9:0] prevX;
  logic [9:0] nextX;
  int dotClocks;

  vicCore dut_i (
    .clk_dot4x  (clk_dot4x),
    .rst        (rst),
    .ce         (ce),
    .rw         (rw),
    .adi        (adi),
    .dbi        (dbi),
    .clkPhi     (clkPhi),
    .dbo        (dbo),
    .irq        (irq),
    .rasterX    (rasterX),
    .rasterLine (rasterLine),
    .colorIndex (colorIndex)
  );

  initial begin
    clk_dot4x = 1'b0;
    forever #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;
  end

  // --------------------------------------------------
  // vector file reader, lines starting with # skipped
  // --------------------------------------------------
  task automatic loadVectors();
    int fd;
    int code;
    int ch;
    logic [7:0] cmd;
    fd = $fopen("verification/vicVectors.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/vicVectors.txt for reading");
      errorCount++;
    end else begin
      code = $fscanf(fd, " %c", cmd);
      while (code == 1 && vecCount < MAX_VECTORS) begin
        if (cmd == "#") begin
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else begin
          code = $fscanf(fd, " %h %h %h", vecAddr[vecCount], vecData[vecCount],
                         vecExpect[vecCount]);
          if (code != 3) begin
            $display("vector %0d is missing its address, data or expected field", vecCount);
            errorCount++;
          end
          vecCmd[vecCount] = cmd;
          vecCount++;
        end
        code = $fscanf(fd, " %c", cmd);
      end
      $fclose(fd);
    end
    vectorsLoaded = 1'b1;
  endtask

  // --------------------------------------------------
  // cpu bus, one access per phi high phase
  // --------------------------------------------------
  task automatic busAccess(input logic readNotWrite, input logic [5:0] addr,
                           input logic [7:0] data);
    @(posedge clkPhi);
    ce  <= 1'b0;
    rw  <= readNotWrite;
    adi <= addr;
    dbi <= data;
    @(negedge clkPhi);
    ce <= 1'b1;
    rw <= 1'b1;
    // dbo and the line are held through the low phase
    @(negedge clk_dot4x);
  endtask

  // nonzero useLine takes bit 7 of control 1, or all of the line register, from the beam
  task automatic readCheck(input logic [5:0] addr, input logic [7:0] useLine,
                           input logic [7:0] expected);
    logic [7:0] want;
    busAccess(1'b1, addr, 8'h00);
    want = expected;
    if (useLine != 8'h00) begin
      if (addr == REG_SCREEN_CONTROL_1) begin
        want = {rasterLine[8], expected[6:0]};
      end else begin
        want = rasterLine[7:0];
      end
    end
    checkCount++;
    if (dbo !== want) begin
      $display("** Error: dbo got 0x%02h expected 0x%02h at address 0x%02h", dbo, want, addr);
      errorCount++;
    end
  endtask

  task automatic waitLine(input logic [8:0] line);
    while (rasterLine != line) begin
      @(negedge clk_dot4x);
    end
  endtask

  // xpos runs XPOS_LINE_START dots ahead of raster x, modulo the line length
  task automatic colorCheck(input int xpos, input logic [3:0] expected);
    int span;
    int target;
    span = `RASTER_X_MAX + 1;
    target = (xpos + span - `XPOS_LINE_START) % span;
    while (rasterX != target) begin
      @(negedge clk_dot4x);
    end
    // three dots on, past the two clock colour pipeline
    repeat (12) @(negedge clk_dot4x);
    checkCount++;
    if (colorIndex !== expected) begin
      $display("** Error: colorIndex got 0x%h expected 0x%h on line 0x%03h xpos 0x%03h",
               colorIndex, expected, rasterLine, xpos);
      errorCount++;
    end
  endtask

  task automatic irqCheck(input logic expected);
    @(negedge clk_dot4x);
    checkCount++;
    if (irq !== expected) begin
      $display("** Error: irq got 0x%h expected 0x%h", irq, expected);
      errorCount++;
    end
  endtask

  task automatic runVector(input int i);
    case (vecCmd[i])
      "W": busAccess(1'b0, vecAddr[i][5:0], vecData[i]);
      "R": readCheck(vecAddr[i][5:0], vecData[i], vecExpect[i]);
      "L": waitLine(vecAddr[i][8:0]);
      "C": colorCheck(vecAddr[i], vecExpect[i][3:0]);
      "Q": irqCheck(vecExpect[i][0]);
      default: begin
        $display("vector %0d has an unknown command letter", i);
        errorCount++;
      end
    endcase
  endtask

  // --------------------------------------------------
  // line monitor, every change is +1 or 311 to 0
  // --------------------------------------------------
  always @(negedge clk_dot4x) begin
    if (rst) begin
      prevLine = rasterLine;
    end else if (rasterLine != prevLine) begin
      nextLine = (prevLine == `RASTER_Y_MAX) ? 9'd0 : prevLine + 9'd1;
      if (rasterLine !== nextLine) begin
        $display("** Error: rasterLine got 0x%03h expected 0x%03h", rasterLine, nextLine);
        lineErrors++;
      end
      if (rasterLine == 9'd0) begin
        wrapCount++;
      end
      prevLine = rasterLine;
    end
  end

  // --------------------------------------------------
  // phi and raster x monitor
  // --------------------------------------------------
  // phi low in reset, then 16 clocks per phase
  // x steps by one every 4 clocks, 503 wraps to 0
  always @(negedge clk_dot4x) begin
    if (rst) begin
      if (clkPhi !== 1'b0) begin
        $display("** Error: clkPhi got 0x%h expected 0x0 during reset", clkPhi);
        timingErrors++;
      end
      prevPhi = 1'b0;
      phiClocks = 0;
      prevX = rasterX;
      dotClocks = -1;
    end else begin
      if (clkPhi !== prevPhi) begin
        if (phiClocks != `PHASE_TICKS) begin
          $display("clkPhi changed after %0d clocks instead of %0d",
                   phiClocks, `PHASE_TICKS);
          timingErrors++;
        end
        prevPhi = clkPhi;
        phiClocks = 1;
      end else begin
        phiClocks++;
      end
      if (rasterX !== prevX) begin
        nextX = (prevX == `RASTER_X_MAX) ? 10'd0 : prevX + 10'd1;
        if (rasterX !== nextX) begin
          $display("** Error: rasterX got 0x%03h expected 0x%03h", rasterX, nextX);
          timingErrors++;
        end
        // first step after reset has no reference point
        if (dotClocks >= 0 && dotClocks != 4) begin
          $display("rasterX stepped after %0d clocks instead of 4", dotClocks);
          timingErrors++;
        end
        prevX = rasterX;
        dotClocks = 1;
      end else if (dotClocks >= 0) begin
        dotClocks++;
      end
    end
  end

  initial begin
    rst <= 1'b1;
    ce  <= 1'b1;
    rw  <= 1'b1;
    adi <= 6'h00;
    dbi <= 8'h00;
    vecCount = 0;
    checkCount = 0;
    errorCount = 0;
    lineErrors = 0;
    wrapCount = 0;
    timingErrors = 0;
    vectorsLoaded = 1'b0;
    loadVectors();
    repeat (16) @(posedge clk_dot4x);
    rst <= 1'b0;
    @(negedge clk_dot4x);
    for (int i = 0; i < vecCount; i++) begin
      runVector(i);
    end
    if (wrapCount == 0) begin
      $display("the raster line never wrapped from the last line to line 0");
      errorCount++;
    end
    $display("%0d checks, %0d value errors, %0d line step errors, %0d timing errors",
             checkCount, errorCount, lineErrors, timingErrors);
    if (errorCount == 0 && lineErrors == 0 && timingErrors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog, vector budget plus three frames
  initial begin : watchdog
    longint timeoutNs;
    wait (vectorsLoaded);
    timeoutNs = (longint'(vecCount) * VECTOR_CLOCKS +
                 3 * (`RASTER_Y_MAX + 1) * (`RASTER_X_MAX + 1) * 4) * CLK_PERIOD;
    #(timeoutNs);
    $display("run timed out after %0d ns before all vectors finished", timeoutNs);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* verification/vicVectors.txt */
# columns: cmd addr data expect, hex; W write, R read, L wait line, C colour at xpos, Q irq
# R with data 01 takes bit 7 of reg 11, or all of reg 12, from the live raster line
Q 00 00 00
R 11 01 1B
W 20 0E 00
R 20 00 FE
W 21 06 00
R 21 00 F6
W 22 0A 00
R 22 00 FA
W 23 05 00
R 23 00 F5
W 24 0D 00
R 24 00 FD
W 16 08 00
W 19 01 00
R 19 00 7E
W 12 64 00
L 14 00 00
C B4 00 0E
L 65 00 00
R 19 00 7F
Q 00 00 00
W 1A 01 00
Q 00 00 01
R 19 00 FF
L 96 00 00
C B4 00 06
C 17C 00 0E
W 19 01 00
Q 00 00 00
L 104 00 00
R 11 01 1B
R 12 01 00
W 11 13 00
L 35 00 00
C B4 00 0E
L 63 00 00
Q 00 00 00
L 65 00 00
Q 00 00 01

/* flist.f */
+incdir+include
hw/vicPkg.sv
hw/vicIf.sv
hw/vicClockGen.sv
hw/vicRegDecode.sv
hw/vicRasterTiming.sv
hw/vicBorderColor.sv
hw/vicCore.sv
verification/vicCoreTb.sv

/* Bender.yml */
package:
  name: vic_core

export_include_dirs:
  - include

sources:
  - hw/vicPkg.sv
  - hw/vicIf.sv
  - hw/vicClockGen.sv
  - hw/vicRegDecode.sv
  - hw/vicRasterTiming.sv
  - hw/vicBorderColor.sv
  - hw/vicCore.sv
  - target: simulation
    files:
      - verification/vicCoreTb.sv
